// ==== alu.sv ====
// combinational MIPS alu for the execute stage, driven by the decoded alu_op
`timescale 1ns/1ps

module alu (
    input  cpu_types_pkg::aluop_t op,
    input  cpu_types_pkg::word_t  a,
    input  cpu_types_pkg::word_t  b,
    input  logic [4:0]            shamt,
    output cpu_types_pkg::word_t  result,
    output logic                  zero
);
    import cpu_types_pkg::*;

    always_comb begin
        case (op)
            // arithmetic, overflow ignored like addu/subu
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            // bitwise logic
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_NOR: begin
                result = ~(a | b);
            end
            // set on less than, signed
            ALU_SLT: begin
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            // set on less than, unsigned
            ALU_SLTU: begin
                result = (a < b) ? 32'd1 : 32'd0;
            end
            // shifts work on rt (b), amount from the shamt field
            ALU_SLL: begin
                result = b << shamt;
            end
            ALU_SRL: begin
                result = b >> shamt;
            end
            // unused encodings
            default: begin
                result = '0;
            end
        endcase
    end

    // branch compare uses this on a subtract
    assign zero = (result == '0);

endmodule

// ==== cpu_types_pkg.sv ====
// shared datapath types, pipeline payloads and memory sizing, imported by every stage of the slice
package cpu_types_pkg;

    // datapath widths
    localparam int WORD_W = 32;
    localparam int REG_AW = 5;

    // data memory sizing
    // 256 words, so word address bits 9..2
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW = 8;

    // one data or address word
    typedef logic [WORD_W-1:0] word_t;

    // register file index
    typedef logic [REG_AW-1:0] regbits_t;

    // alu operation select
    // encoding is what decode hands over on alu_op
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9
    } aluop_t;

    // EX/MEM payload
    // control strobes first, then destination, then data
    typedef struct packed {
        // write register file at writeback
        logic     reg_wr;
        // take load data instead of alu result
        logic     mem_to_reg;
        // data memory read
        logic     dren;
        // data memory write
        logic     dwen;
        // end of program marker
        logic     halt;
        // destination register
        regbits_t wsel;
        // alu output, lui value or link address
        word_t    alu_result;
        // rt value for stores
        word_t    store_data;
    } ex_mem_t;

    // MEM/WB payload
    // only what writeback needs
    typedef struct packed {
        logic     reg_wr;
        logic     halt;
        regbits_t wsel;
        // load data or alu result, already selected
        word_t    wb_data;
    } mem_wb_t;

endpackage

// ==== data_ram.sv ====
// word-addressed data memory with one wait state: dhit one cycle after a request is first seen
`timescale 1ns/1ps

module data_ram (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 ren,
    input  logic                 wen,
    input  cpu_types_pkg::word_t addr,
    input  cpu_types_pkg::word_t wdata,
    output cpu_types_pkg::word_t rdata,
    output logic                 dhit
);
    import cpu_types_pkg::*;

    word_t              mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;
    logic               req;
    logic               pending;

    // word index, bits 9..2 of the byte address
    assign idx = addr[DMEM_AW+1:2];
    assign req = ren | wen;

    // first-cycle flag
    // set after the first cycle of a request, cleared after the hit
    // so back-to-back requests each wait once
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pending <= 1'b0;
        end else begin
            pending <= req & ~pending;
        end
    end

    assign dhit = pending;

    // array clears on reset, store lands at the end of the hit cycle
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen && pending) begin
            mem[idx] <= wdata;
        end
    end

    // read during the wait cycle, data valid in the hit cycle
    always_ff @(posedge CLK) begin
        if (ren && !pending) begin
            rdata <= mem[idx];
        end
    end

    // the requester must keep the request up through the hit
    a_hit_has_request : assert property (
        @(posedge CLK) disable iff (!nRST)
        dhit |-> req)
        else $error("request dropped before the memory hit");

endmodule

// ==== ex_mem_pipe.f ====
cpu_types_pkg.sv
alu.sv
execute_stage.sv
pipe_reg.sv
mem_stage.sv
data_ram.sv
ex_mem_pipe.sv
tb_ex_mem_pipe.sv

// ==== ex_mem_pipe.sv ====
// top of the execute-to-writeback slice: EX, EX/MEM, MEM with data memory, MEM/WB
`timescale 1ns/1ps

module ex_mem_pipe (
    input  logic                    CLK,
    input  logic                    nRST,
    // ID/EX data
    input  cpu_types_pkg::word_t    rdat1,
    input  cpu_types_pkg::word_t    rdat2,
    input  cpu_types_pkg::word_t    ext_imm,
    input  logic [4:0]              shamt,
    input  cpu_types_pkg::word_t    pcplusfour,
    input  logic [25:0]             j_addr,
    input  cpu_types_pkg::regbits_t wsel,
    // ID/EX operation
    input  cpu_types_pkg::aluop_t   alu_op,
    input  logic                    alu_src,
    // ID/EX control strobes
    input  logic                    reg_wr,
    input  logic                    mem_to_reg,
    input  logic                    dren,
    input  logic                    dwen,
    input  logic                    beq,
    input  logic                    bne,
    input  logic                    jump,
    input  logic                    jal,
    input  logic                    jr,
    input  logic                    lui,
    input  logic                    halt,
    // to fetch
    output logic                    pc_sel,
    output cpu_types_pkg::word_t    pc_target,
    // upstream must hold while high
    output logic                    stall,
    // writeback
    output logic                    wb_reg_wr,
    output cpu_types_pkg::regbits_t wb_wsel,
    output cpu_types_pkg::word_t    wb_data,
    output logic                    wb_halt
);
    import cpu_types_pkg::*;

    ex_mem_t ex_d;
    ex_mem_t ex_q;
    mem_wb_t wb_d;
    mem_wb_t wb_q;
    logic    dmem_ren;
    logic    dmem_wen;
    word_t   dmem_addr;
    word_t   dmem_wdata;
    word_t   dmem_rdata;
    logic    dhit;

    execute_stage ex_i (
        .rdat1      (rdat1),
        .rdat2      (rdat2),
        .ext_imm    (ext_imm),
        .shamt      (shamt),
        .pcplusfour (pcplusfour),
        .j_addr     (j_addr),
        .alu_op     (alu_op),
        .alu_src    (alu_src),
        .beq        (beq),
        .bne        (bne),
        .jump       (jump),
        .jal        (jal),
        .jr         (jr),
        .lui        (lui),
        .reg_wr     (reg_wr),
        .mem_to_reg (mem_to_reg),
        .dren       (dren),
        .dwen       (dwen),
        .halt       (halt),
        .wsel       (wsel),
        .ex_out     (ex_d),
        .pc_sel     (pc_sel),
        .pc_target  (pc_target)
    );

    // holds the memory instruction through its wait state
    pipe_reg #(.payload_t(ex_mem_t), .bubble_on_stall(1'b0)) ex_mem_reg (
        .CLK   (CLK),
        .nRST  (nRST),
        .stall (stall),
        .d     (ex_d),
        .q     (ex_q)
    );

    mem_stage mem_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .mem_in     (ex_q),
        .dmem_rdata (dmem_rdata),
        .dhit       (dhit),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .stall      (stall),
        .wb_out     (wb_d)
    );

    data_ram dmem_i (
        .CLK   (CLK),
        .nRST  (nRST),
        .ren   (dmem_ren),
        .wen   (dmem_wen),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata),
        .dhit  (dhit)
    );

    // empty slot into writeback while waiting on memory
    pipe_reg #(.payload_t(mem_wb_t), .bubble_on_stall(1'b1)) mem_wb_reg (
        .CLK   (CLK),
        .nRST  (nRST),
        .stall (stall),
        .d     (wb_d),
        .q     (wb_q)
    );

    assign wb_reg_wr = wb_q.reg_wr;
    assign wb_wsel   = wb_q.wsel;
    assign wb_data   = wb_q.wb_data;
    assign wb_halt   = wb_q.halt;

endmodule

// ==== execute_stage.sv ====
// execute stage: operand select, alu, lui/jal result choice and branch/jump resolution for fetch
`timescale 1ns/1ps

module execute_stage (
    input  cpu_types_pkg::word_t    rdat1,
    input  cpu_types_pkg::word_t    rdat2,
    input  cpu_types_pkg::word_t    ext_imm,
    input  logic [4:0]              shamt,
    input  cpu_types_pkg::word_t    pcplusfour,
    input  logic [25:0]             j_addr,
    input  cpu_types_pkg::aluop_t   alu_op,
    input  logic                    alu_src,
    input  logic                    beq,
    input  logic                    bne,
    input  logic                    jump,
    input  logic                    jal,
    input  logic                    jr,
    input  logic                    lui,
    input  logic                    reg_wr,
    input  logic                    mem_to_reg,
    input  logic                    dren,
    input  logic                    dwen,
    input  logic                    halt,
    input  cpu_types_pkg::regbits_t wsel,
    output cpu_types_pkg::ex_mem_t  ex_out,
    output logic                    pc_sel,
    output cpu_types_pkg::word_t    pc_target
);
    import cpu_types_pkg::*;

    aluop_t op_sel;
    word_t  opb;
    word_t  alu_res;
    logic   alu_zero;
    logic   is_branch;
    logic   br_taken;
    word_t  br_target;
    word_t  j_target;

    assign is_branch = beq | bne;

    // branches always compare rs - rt, whatever decode put on alu_op
    assign op_sel = is_branch ? ALU_SUB : alu_op;
    assign opb    = (alu_src && !is_branch) ? ext_imm : rdat2;

    alu alu_i (
        .op     (op_sel),
        .a      (rdat1),
        .b      (opb),
        .shamt  (shamt),
        .result (alu_res),
        .zero   (alu_zero)
    );

    // pc relative branch, word offset
    assign br_target = pcplusfour + (ext_imm << 2);
    // pseudo-direct jump inside the current 256MB region
    assign j_target  = {pcplusfour[31:28], j_addr, 2'b00};
    assign br_taken  = (beq && alu_zero) || (bne && !alu_zero);

    assign pc_sel = br_taken | jump | jal | jr;

    // next fetch address, falls through when nothing is taken
    always_comb begin
        if (jr) begin
            pc_target = rdat1;
        end else if (jump || jal) begin
            pc_target = j_target;
        end else if (br_taken) begin
            pc_target = br_target;
        end else begin
            pc_target = pcplusfour;
        end
    end

    // payload for EX/MEM
    always_comb begin
        ex_out.reg_wr     = reg_wr;
        ex_out.mem_to_reg = mem_to_reg;
        ex_out.dren       = dren;
        ex_out.dwen       = dwen;
        ex_out.halt       = halt;
        ex_out.wsel       = wsel;
        ex_out.store_data = rdat2;
        // lui loads the upper half, jal links the return address
        if (lui) begin
            ex_out.alu_result = ext_imm << 16;
        end else if (jal) begin
            ex_out.alu_result = pcplusfour;
        end else begin
            ex_out.alu_result = alu_res;
        end
    end

    // decode hands over at most one control transfer per instruction
    always_comb begin
        assert #0 ($onehot0({beq, bne, jump, jal, jr}))
            else $error("more than one of beq, bne, jump, jal, jr is high");
    end

endmodule

// ==== mem_stage.sv ====
// memory stage: issues the data memory request, stalls until hit, and picks the writeback value
`timescale 1ns/1ps

module mem_stage (
    input  logic                   CLK,
    input  logic                   nRST,
    input  cpu_types_pkg::ex_mem_t mem_in,
    input  cpu_types_pkg::word_t   dmem_rdata,
    input  logic                   dhit,
    output logic                   dmem_ren,
    output logic                   dmem_wen,
    output cpu_types_pkg::word_t   dmem_addr,
    output cpu_types_pkg::word_t   dmem_wdata,
    output logic                   stall,
    output cpu_types_pkg::mem_wb_t wb_out
);
    import cpu_types_pkg::*;

    logic req;

    // request straight from the EX/MEM strobes
    assign dmem_ren   = mem_in.dren;
    assign dmem_wen   = mem_in.dwen;
    // byte address from the alu, memory drops the low two bits
    assign dmem_addr  = mem_in.alu_result;
    assign dmem_wdata = mem_in.store_data;

    assign req = mem_in.dren | mem_in.dwen;

    // wait state until the memory answers
    assign stall = req & ~dhit;

    // writeback payload
    assign wb_out.reg_wr  = mem_in.reg_wr;
    assign wb_out.halt    = mem_in.halt;
    assign wb_out.wsel    = mem_in.wsel;
    assign wb_out.wb_data = mem_in.mem_to_reg ? dmem_rdata : mem_in.alu_result;

    // a load and a store in one slot is a decode fault
    a_rw_exclusive : assert property (
        @(posedge CLK) disable iff (!nRST)
        !(mem_in.dren && mem_in.dwen))
        else $error("data read and write requested together");

    // EX/MEM holds the request, so the hit must come the next cycle
    a_stall_one_cycle : assert property (
        @(posedge CLK) disable iff (!nRST)
        stall |=> !stall)
        else $error("memory stall lasted more than one cycle");

    // word accesses only
    a_word_aligned : assert property (
        @(posedge CLK) disable iff (!nRST)
        req |-> (mem_in.alu_result[1:0] == 2'b00))
        else $error("data memory address is not word aligned");

endmodule

// ==== pipe_reg.sv ====
// generic pipeline register for any packed payload, holding or bubbling while the pipe stalls
`timescale 1ns/1ps

module pipe_reg #(
    // payload struct carried between stages
    parameter type payload_t       = logic [31:0],
    // high loads zeros on stall instead of holding
    parameter bit  bubble_on_stall = 1'b0
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     stall,
    input  payload_t d,
    output payload_t q
);

    // whole payload clears on reset
    // an all-zero payload carries no reg_wr, halt or memory strobe
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            q <= '0;
        end else if (!stall) begin
            // normal advance
            q <= d;
        end else if (bubble_on_stall) begin
            // insert a nop downstream of the stall point
            q <= '0;
        end else begin
            // keep the instruction upstream of the stall point
            q <= q;
        end
    end

endmodule

// ==== tb_ex_mem_pipe.sv ====
// testbench for the EX-to-WB slice that drives ID/EX inputs, models writebacks and checks them
`timescale 1ns/1ps

module tb_ex_mem_pipe;
    import cpu_types_pkg::*;

    // one expected writeback slot
    typedef struct {
        int       cyc;
        logic     wr;
        logic     halt;
        regbits_t wsel;
        word_t    data;
    } wb_exp_t;

    logic        CLK;
    logic        nRST;
    word_t       rdat1, rdat2, ext_imm, pcplusfour;
    logic [4:0]  shamt;
    logic [25:0] j_addr;
    regbits_t    wsel;
    aluop_t      alu_op;
    logic        alu_src, reg_wr, mem_to_reg, dren, dwen;
    logic        beq, bne, jump, jal, jr, lui, halt;
    logic        pc_sel, stall, wb_reg_wr, wb_halt;
    word_t       pc_target, wb_data;
    regbits_t    wb_wsel;

    // reference model state
    wb_exp_t exp_q[$];
    wb_exp_t front;
    bit      have_exp;
    word_t   model_mem [DMEM_WORDS];
    integer  seed;
    int      cyc = 0;
    int      stall_cyc;
    bit      started;
    bit      halt_seen;
    // expected fetch redirect for the instruction on the inputs
    logic    exp_sel;
    word_t   exp_tgt;

    ex_mem_pipe dut_i (.*);

    initial begin
        CLK = 1'b0;
        forever begin
            #4 CLK = ~CLK;
        end
    end

    // edge counter used as the time base for writeback and stall slots
    always @(posedge CLK) begin
        cyc <= cyc + 1;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic peek_front();
        have_exp = (exp_q.size() > 0);
        if (have_exp) begin
            front = exp_q[0];
        end
    endtask

    // retire the oldest expected slot when the DUT writes back
    always @(posedge CLK) begin
        if (nRST && (wb_reg_wr || wb_halt) && have_exp) begin
            halt_seen = halt_seen | wb_halt;
            void'(exp_q.pop_front());
            peek_front();
        end
    end

    // MIPS alu semantics
    function automatic word_t expect_alu(aluop_t op, word_t a, word_t b, logic [4:0] sh);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'd0, a < b};
            ALU_SLL:  return b << sh;
            ALU_SRL:  return b >> sh;
            default:  return '0;
        endcase
    endfunction

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    task automatic clear_inputs();
        {rdat1, rdat2, ext_imm, pcplusfour} = '0;
        shamt  = '0;
        j_addr = '0;
        wsel   = '0;
        alu_op = ALU_ADD;
        {alu_src, reg_wr, mem_to_reg, dren, dwen} = '0;
        {beq, bne, jump, jal, jr, lui, halt} = '0;
    endtask

    // present the instruction already on the inputs until the pipe takes it
    task automatic send(input bit mem_op, input word_t wb_val, input bit sel, input word_t tgt);
        wb_exp_t e;
        int      waited;
        exp_sel = sel;
        exp_tgt = tgt;
        started = 1'b1;
        waited  = 0;
        @(negedge CLK);
        // held while the memory op ahead waits for its hit
        while (stall) begin
            waited++;
            if (waited > 8) begin
                stop_run("instruction was never accepted, stall stayed high");
            end
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
        if (mem_op) begin
            stall_cyc = cyc;
        end
        if (reg_wr || halt) begin
            // EX/MEM then MEM/WB plus the memory wait state
            e.cyc  = cyc + 1 + mem_op;
            e.wr   = reg_wr;
            e.halt = halt;
            e.wsel = wsel;
            e.data = wb_val;
            exp_q.push_back(e);
            peek_front();
        end
    endtask

    task automatic alu_instr(input aluop_t op, input bit imm);
        word_t r;
        clear_inputs();
        r       = rand_word();
        rdat1   = rand_word();
        rdat2   = rand_word();
        ext_imm = {{16{r[15]}}, r[15:0]};
        shamt   = r[20:16];
        wsel    = r[25:21];
        alu_op  = op;
        alu_src = imm;
        reg_wr  = 1'b1;
        send(1'b0, expect_alu(op, rdat1, imm ? ext_imm : rdat2, shamt), 1'b0, '0);
    endtask

    // sw uses base plus offset addressing and writes no register
    task automatic store_word(input word_t addr, input word_t data);
        clear_inputs();
        rdat1   = addr - 32'd8;
        ext_imm = 32'd8;
        rdat2   = data;
        alu_src = 1'b1;
        dwen    = 1'b1;
        model_mem[addr[9:2]] = data;
        send(1'b1, '0, 1'b0, '0);
    endtask

    task automatic load_word(input word_t addr, input regbits_t dst);
        clear_inputs();
        rdat1      = addr - 32'd8;
        ext_imm    = 32'd8;
        alu_src    = 1'b1;
        dren       = 1'b1;
        mem_to_reg = 1'b1;
        reg_wr     = 1'b1;
        wsel       = dst;
        send(1'b1, model_mem[addr[9:2]], 1'b0, '0);
    endtask

    task automatic branch_instr(input bit is_beq, input bit equal);
        word_t r;
        word_t p;
        clear_inputs();
        r          = rand_word();
        p          = rand_word();
        rdat1      = rand_word();
        rdat2      = equal ? rdat1 : (rdat1 ^ (r | 32'd1));
        ext_imm    = {{16{r[15]}}, r[15:0]};
        pcplusfour = {p[31:2], 2'b00};
        alu_op     = ALU_SUB;
        beq        = is_beq;
        bne        = !is_beq;
        send(1'b0, '0, is_beq ? equal : !equal, pcplusfour + (ext_imm << 2));
    endtask

    // j or jal where jal links to r31
    task automatic jump_instr(input bit link);
        word_t r;
        clear_inputs();
        r          = rand_word();
        pcplusfour = {r[31:2], 2'b00};
        r          = rand_word();
        j_addr     = r[25:0];
        jump       = !link;
        jal        = link;
        reg_wr     = link;
        wsel       = 5'd31;
        send(1'b0, pcplusfour, 1'b1, {pcplusfour[31:28], j_addr, 2'b00});
    endtask

    task automatic register_jump();
        word_t r;
        clear_inputs();
        r     = rand_word();
        rdat1 = {r[31:2], 2'b00};
        jr    = 1'b1;
        send(1'b0, '0, 1'b1, rdat1);
    endtask

    task automatic lui_instr();
        word_t r;
        clear_inputs();
        r       = rand_word();
        ext_imm = {16'd0, r[15:0]};
        alu_src = 1'b1;
        lui     = 1'b1;
        reg_wr  = 1'b1;
        wsel    = r[20:16];
        send(1'b0, {r[15:0], 16'd0}, 1'b0, '0);
    endtask

    // quiet pipe out of reset
    a_reset_quiet : assert property (@(posedge CLK) disable iff (!nRST)
        !started |-> (!wb_reg_wr && !wb_halt && !stall && wb_data == '0))
        else stop_run($sformatf("FAIL %0t: writeback or stall active before first instr", $time));

    // writeback value, order and slot
    a_wb_expected : assert property (@(posedge CLK) disable iff (!nRST)
        (wb_reg_wr || wb_halt) |-> (have_exp && cyc == front.cyc && wb_reg_wr == front.wr
            && wb_halt == front.halt && wb_wsel == front.wsel && wb_data == front.data))
        else stop_run($sformatf("FAIL %0t: writeback wsel %0d data %h, expected wsel %0d data %h",
            $time, wb_wsel, wb_data, $sampled(front.wsel), $sampled(front.data)));

    a_wb_on_time : assert property (@(posedge CLK) disable iff (!nRST)
        (have_exp && cyc == front.cyc) |-> (wb_reg_wr || wb_halt))
        else stop_run($sformatf("FAIL %0t: writeback to r%0d missing", $time, front.wsel));

    // exactly one wait cycle per load or store
    a_stall_window : assert property (@(posedge CLK) disable iff (!nRST)
        started |-> (stall == (cyc == stall_cyc)))
        else stop_run($sformatf("FAIL %0t: stall is %b outside its one-cycle window", $time, stall));

    a_fetch_redirect : assert property (@(posedge CLK) disable iff (!nRST)
        started |-> (pc_sel == exp_sel && (!exp_sel || pc_target == exp_tgt)))
        else stop_run($sformatf("FAIL %0t: pc_sel %b target %h, expected %b %h",
            $time, pc_sel, pc_target, exp_sel, exp_tgt));

    initial begin
        word_t r;
        int    waited;
        seed      = 32'hed19_d1b1;
        nRST      = 1'b0;
        started   = 1'b0;
        halt_seen = 1'b0;
        have_exp  = 1'b0;
        stall_cyc = -1;
        exp_sel   = 1'b0;
        exp_tgt   = '0;
        clear_inputs();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (5) @(posedge CLK);
        #1;
        nRST = 1'b1;
        // a few idle cycles to observe the reset state
        repeat (3) @(posedge CLK);
        #1;
        // every alu op in register and immediate form
        for (int i = 0; i < 10; i++) begin
            alu_instr(aluop_t'(i), 1'b0);
            alu_instr(aluop_t'(i), 1'b1);
        end
        store_word(32'h0000_0040, rand_word());
        load_word(32'h0000_0040, 5'd3);
        // never written
        load_word(32'h0000_03fc, 5'd4);
        store_word(32'h0000_0080, rand_word());
        store_word(32'h0000_0084, rand_word());
        load_word(32'h0000_0084, 5'd5);
        alu_instr(ALU_XOR, 1'b0);
        load_word(32'h0000_0080, 5'd6);
        // random mix of alu, store and load
        for (int i = 0; i < 24; i++) begin
            r = rand_word();
            case (r[1:0])
                2'd0: store_word({22'd0, r[15:8], 2'b00}, rand_word());
                2'd1: load_word({22'd0, r[15:8], 2'b00}, r[20:16]);
                default: alu_instr(aluop_t'(int'(r[7:4]) % 10), r[2]);
            endcase
        end
        // control transfers both taken and not taken
        branch_instr(1'b1, 1'b1);
        branch_instr(1'b1, 1'b0);
        branch_instr(1'b0, 1'b1);
        branch_instr(1'b0, 1'b0);
        jump_instr(1'b0);
        jump_instr(1'b1);
        register_jump();
        lui_instr();
        clear_inputs();
        halt = 1'b1;
        send(1'b0, '0, 1'b0, '0);
        clear_inputs();
        waited = 0;
        while (!halt_seen || exp_q.size() != 0) begin
            waited++;
            if (waited > 20) begin
                stop_run("halt writeback never appeared");
            end
            @(negedge CLK);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule
